// ==== hdl/wb_pkg.sv ====
`default_nettype none

package wb_pkg;

    localparam int PIX_W      = 8;
    localparam int SUM_W      = 24;                 // frames up to 65536 pixels.
    localparam int DIV_W      = SUM_W + 2;          // holds three times a sum.
    localparam int GAIN_W     = 10;
    localparam int GAIN_FRAC  = 8;
    localparam int NUM_W      = DIV_W + GAIN_FRAC;  // total of sums, scaled.
    localparam int STEP_W     = 4;                  // counts GAIN_W divider steps.
    localparam int PROD_W     = PIX_W + GAIN_W;

    localparam logic [PIX_W-1:0]  PIX_MAX    = 8'hFF;
    localparam logic [GAIN_W-1:0] GAIN_UNITY = 10'd256;
    localparam logic [GAIN_W-1:0] GAIN_MAX   = 10'd1023;

    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_AW    = 3;
    localparam int FIFO_W     = 3 * PIX_W + 1;      // {last, r, g, b}.

    typedef enum logic [2:0] {
        DIV_IDLE,
        DIV_LOAD,
        DIV_STEP,
        DIV_NEXT,
        DIV_PUBLISH
    } div_state_t;

endpackage : wb_pkg

`default_nettype wire

// ==== hdl/wb_frame_stats.sv ====
`timescale 1ns/10ps
`default_nettype none

module wb_frame_stats (
    input  wire                       clk,
    input  wire                       i_rst_n,
    input  wire                       i_valid,
    input  wire                       i_ready,
    input  wire  [wb_pkg::PIX_W-1:0]  i_r,
    input  wire  [wb_pkg::PIX_W-1:0]  i_g,
    input  wire  [wb_pkg::PIX_W-1:0]  i_b,
    input  wire                       i_last,
    output logic [wb_pkg::SUM_W-1:0]  o_sum_r,
    output logic [wb_pkg::SUM_W-1:0]  o_sum_g,
    output logic [wb_pkg::SUM_W-1:0]  o_sum_b,
    output logic                      o_sums_valid
);
    import wb_pkg::*;

    logic [SUM_W-1:0] acc_r;
    logic [SUM_W-1:0] acc_g;
    logic [SUM_W-1:0] acc_b;
    logic [SUM_W-1:0] nxt_r;
    logic [SUM_W-1:0] nxt_g;
    logic [SUM_W-1:0] nxt_b;
    logic             xfer;

    assign xfer  = i_valid && i_ready;
    assign nxt_r = acc_r + SUM_W'(i_r);
    assign nxt_g = acc_g + SUM_W'(i_g);
    assign nxt_b = acc_b + SUM_W'(i_b);

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            acc_r        <= '0;
            acc_g        <= '0;
            acc_b        <= '0;
            o_sum_r      <= '0;
            o_sum_g      <= '0;
            o_sum_b      <= '0;
            o_sums_valid <= 1'b0;
        end else begin
            o_sums_valid <= 1'b0;
            if (xfer) begin
                if (i_last) begin
                    o_sum_r      <= nxt_r;  // totals include the last pixel.
                    o_sum_g      <= nxt_g;
                    o_sum_b      <= nxt_b;
                    acc_r        <= '0;
                    acc_g        <= '0;
                    acc_b        <= '0;
                    o_sums_valid <= 1'b1;
                end else begin
                    acc_r <= nxt_r;
                    acc_g <= nxt_g;
                    acc_b <= nxt_b;
                end
            end
        end
    end

endmodule : wb_frame_stats

`default_nettype wire

// ==== hdl/wb_gain_calc.sv ====
`timescale 1ns/10ps
`default_nettype none

module wb_gain_calc (
    input  wire                        clk,
    input  wire                        i_rst_n,
    input  wire  [wb_pkg::SUM_W-1:0]   i_sum_r,
    input  wire  [wb_pkg::SUM_W-1:0]   i_sum_g,
    input  wire  [wb_pkg::SUM_W-1:0]   i_sum_b,
    input  wire                        i_sums_valid,
    output logic [wb_pkg::GAIN_W-1:0]  o_gain_r,
    output logic [wb_pkg::GAIN_W-1:0]  o_gain_g,
    output logic [wb_pkg::GAIN_W-1:0]  o_gain_b,
    output logic                       o_gains_valid
);
    import wb_pkg::*;

    div_state_t        state;
    logic [1:0]        ch;
    logic [STEP_W-1:0] cnt;
    logic [SUM_W-1:0]  sum_r;
    logic [SUM_W-1:0]  sum_g;
    logic [SUM_W-1:0]  sum_b;
    logic [SUM_W-1:0]  sum_sel;
    logic [DIV_W-1:0]  total;
    logic [NUM_W-1:0]  num;
    logic [DIV_W-1:0]  div;
    logic [DIV_W-1:0]  div_nx;
    logic [DIV_W-1:0]  rem;
    logic [DIV_W:0]    trial;
    logic [DIV_W:0]    diff;
    logic              fits;
    logic [GAIN_W-1:0] low;
    logic [GAIN_W-1:0] quo;
    logic [GAIN_W-1:0] quo_nx;
    logic [GAIN_W-1:0] gain_res;
    logic [GAIN_W-1:0] res_r;
    logic [GAIN_W-1:0] res_g;
    logic              ovf;
    logic              zero;
    logic              last_step;

    always_comb begin
        case (ch)
            2'd0:    sum_sel = sum_r;
            2'd1:    sum_sel = sum_g;
            default: sum_sel = sum_b;
        endcase
    end

    assign total     = DIV_W'(i_sum_r) + DIV_W'(i_sum_g) + DIV_W'(i_sum_b);
    assign div_nx    = (DIV_W'(sum_sel) << 1) + DIV_W'(sum_sel);
    assign trial     = {rem, low[GAIN_W-1]};  // bring down the next numerator bit.
    assign diff      = trial - {1'b0, div};
    assign fits      = (trial >= {1'b0, div});
    assign quo_nx    = {quo[GAIN_W-2:0], fits};
    assign last_step = (state == DIV_STEP) && (cnt == STEP_W'(GAIN_W - 1));
    assign gain_res  = zero ? GAIN_UNITY : (ovf ? GAIN_MAX : quo_nx);

    // divider datapath.
    always_ff @(posedge clk) begin
        case (state)
            DIV_IDLE: begin
                if (i_sums_valid) begin
                    sum_r <= i_sum_r;
                    sum_g <= i_sum_g;
                    sum_b <= i_sum_b;
                    num   <= {total, {GAIN_FRAC{1'b0}}};
                end
            end
            DIV_LOAD, DIV_NEXT: begin
                div  <= div_nx;
                rem  <= DIV_W'(num[NUM_W-1:GAIN_W]);
                low  <= num[GAIN_W-1:0];
                quo  <= '0;
                zero <= (sum_sel == '0);
                ovf  <= (DIV_W'(num[NUM_W-1:GAIN_W]) >= div_nx);  // quotient above 1023.
            end
            DIV_STEP: begin
                rem <= fits ? diff[DIV_W-1:0] : trial[DIV_W-1:0];
                low <= {low[GAIN_W-2:0], 1'b0};
                quo <= quo_nx;
                if (last_step && ch == 2'd0) begin
                    res_r <= gain_res;
                end
                if (last_step && ch == 2'd1) begin
                    res_g <= gain_res;
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state         <= DIV_IDLE;
            ch            <= 2'd0;
            cnt           <= '0;
            o_gain_r      <= GAIN_UNITY;
            o_gain_g      <= GAIN_UNITY;
            o_gain_b      <= GAIN_UNITY;
            o_gains_valid <= 1'b0;
        end else begin
            o_gains_valid <= 1'b0;
            case (state)
                DIV_IDLE: begin
                    if (i_sums_valid) begin
                        ch    <= 2'd0;
                        state <= DIV_LOAD;
                    end
                end
                DIV_LOAD, DIV_NEXT: begin
                    cnt   <= '0;
                    state <= DIV_STEP;
                end
                DIV_STEP: begin
                    cnt <= cnt + 1'b1;
                    if (last_step) begin
                        if (ch == 2'd2) begin
                            o_gain_r      <= res_r;
                            o_gain_g      <= res_g;
                            o_gain_b      <= gain_res;
                            o_gains_valid <= 1'b1;
                            state         <= DIV_PUBLISH;
                        end else begin
                            ch    <= ch + 1'b1;
                            state <= DIV_NEXT;
                        end
                    end
                end
                DIV_PUBLISH: state <= DIV_IDLE;
                default:     state <= DIV_IDLE;
            endcase
        end
    end

endmodule : wb_gain_calc

`default_nettype wire

// ==== hdl/wb_pixel_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

module wb_pixel_fifo (
    input  wire                        clk,
    input  wire                        i_rst_n,
    input  wire                        i_wr,
    input  wire  [wb_pkg::FIFO_W-1:0]  i_wdata,
    input  wire                        i_rd,
    output logic [wb_pkg::FIFO_W-1:0]  o_rdata,
    output logic                       o_empty,
    output logic                       o_full
);
    import wb_pkg::*;

    logic [FIFO_W-1:0]  mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   count;
    logic               do_wr;
    logic               do_rd;

    assign do_wr   = i_wr && !o_full;
    assign do_rd   = i_rd && !o_empty;
    assign o_rdata = mem[rd_ptr];  // head entry, shown ahead of the read.
    assign o_empty = (count == '0);
    assign o_full  = (count == (FIFO_AW + 1)'(FIFO_DEPTH));

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= i_wdata;
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;  // wraps at the depth.
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule : wb_pixel_fifo

`default_nettype wire

// ==== hdl/wb_gain_apply.sv ====
`timescale 1ns/10ps
`default_nettype none

module wb_gain_apply (
    input  wire                        clk,
    input  wire                        i_rst_n,
    input  wire                        i_wb_en,
    input  wire  [wb_pkg::GAIN_W-1:0]  i_gain_r,
    input  wire  [wb_pkg::GAIN_W-1:0]  i_gain_g,
    input  wire  [wb_pkg::GAIN_W-1:0]  i_gain_b,
    input  wire                        i_gains_valid,
    input  wire  [wb_pkg::FIFO_W-1:0]  i_fifo_data,
    input  wire                        i_fifo_empty,
    input  wire                        i_ready,
    output logic                       o_fifo_rd,
    output logic                       o_valid,
    output logic [wb_pkg::PIX_W-1:0]   o_r,
    output logic [wb_pkg::PIX_W-1:0]   o_g,
    output logic [wb_pkg::PIX_W-1:0]   o_b,
    output logic                       o_last
);
    import wb_pkg::*;

    logic [GAIN_W-1:0] pend_r, pend_g, pend_b;
    logic [GAIN_W-1:0] act_r, act_g, act_b;
    logic [GAIN_W-1:0] use_r, use_g, use_b;
    logic [PIX_W-1:0]  pix_r, pix_g, pix_b;
    logic              pix_last;
    logic              frame_start;
    logic              adv;
    logic              s1_valid;
    logic              s1_last;
    logic [PROD_W-1:0] s1_r, s1_g, s1_b;

    function automatic logic [PIX_W-1:0] clip(input logic [PROD_W-1:0] prod);
        logic [PROD_W-GAIN_FRAC-1:0] scaled;
        scaled = prod[PROD_W-1:GAIN_FRAC];
        return (scaled > PIX_MAX) ? PIX_MAX : scaled[PIX_W-1:0];
    endfunction

    assign {pix_last, pix_r, pix_g, pix_b} = i_fifo_data;

    assign adv       = i_ready;  // whole pipe holds while the sink stalls.
    assign o_fifo_rd = adv && !i_fifo_empty;

    // pending gains apply from the first pixel of a frame.
    assign use_r = !i_wb_en ? GAIN_UNITY : (frame_start ? pend_r : act_r);
    assign use_g = !i_wb_en ? GAIN_UNITY : (frame_start ? pend_g : act_g);
    assign use_b = !i_wb_en ? GAIN_UNITY : (frame_start ? pend_b : act_b);

    always_ff @(posedge clk) begin
        if (o_fifo_rd) begin
            s1_r    <= PROD_W'(pix_r) * PROD_W'(use_r);
            s1_g    <= PROD_W'(pix_g) * PROD_W'(use_g);
            s1_b    <= PROD_W'(pix_b) * PROD_W'(use_b);
            s1_last <= pix_last;
        end
        if (adv && s1_valid) begin
            o_r    <= clip(s1_r);
            o_g    <= clip(s1_g);
            o_b    <= clip(s1_b);
            o_last <= s1_last;
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pend_r      <= GAIN_UNITY;
            pend_g      <= GAIN_UNITY;
            pend_b      <= GAIN_UNITY;
            act_r       <= GAIN_UNITY;
            act_g       <= GAIN_UNITY;
            act_b       <= GAIN_UNITY;
            frame_start <= 1'b1;
            s1_valid    <= 1'b0;
            o_valid     <= 1'b0;
        end else begin
            if (i_gains_valid) begin
                pend_r <= i_gain_r;
                pend_g <= i_gain_g;
                pend_b <= i_gain_b;
            end
            if (o_fifo_rd) begin
                frame_start <= pix_last;
                if (frame_start) begin
                    act_r <= pend_r;
                    act_g <= pend_g;
                    act_b <= pend_b;
                end
            end
            if (adv) begin
                s1_valid <= o_fifo_rd;
                o_valid  <= s1_valid;
            end
        end
    end

endmodule : wb_gain_apply

`default_nettype wire

// ==== hdl/wb_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module wb_top (
    input  wire                       clk,
    input  wire                       i_rst_n,
    input  wire                       i_wb_en,
    input  wire                       i_valid,
    input  wire  [wb_pkg::PIX_W-1:0]  i_r,
    input  wire  [wb_pkg::PIX_W-1:0]  i_g,
    input  wire  [wb_pkg::PIX_W-1:0]  i_b,
    input  wire                       i_last,
    output logic                      o_ready,
    output logic                      o_valid,
    output logic [wb_pkg::PIX_W-1:0]  o_r,
    output logic [wb_pkg::PIX_W-1:0]  o_g,
    output logic [wb_pkg::PIX_W-1:0]  o_b,
    output logic                      o_last,
    input  wire                       i_ready
);
    import wb_pkg::*;

    logic [SUM_W-1:0]  sum_r, sum_g, sum_b;
    logic              sums_valid;
    logic [GAIN_W-1:0] gain_r, gain_g, gain_b;
    logic              gains_valid;
    logic [FIFO_W-1:0] fifo_wdata;
    logic [FIFO_W-1:0] fifo_rdata;
    logic              fifo_wr;
    logic              fifo_rd;
    logic              fifo_empty;
    logic              fifo_full;

    assign o_ready    = !fifo_full;
    assign fifo_wr    = i_valid && o_ready;
    assign fifo_wdata = {i_last, i_r, i_g, i_b};

    wb_frame_stats u_stats (
        .clk          (clk       ),
        .i_rst_n      (i_rst_n   ),
        .i_valid      (i_valid   ),
        .i_ready      (o_ready   ),
        .i_r          (i_r       ),
        .i_g          (i_g       ),
        .i_b          (i_b       ),
        .i_last       (i_last    ),
        .o_sum_r      (sum_r     ),
        .o_sum_g      (sum_g     ),
        .o_sum_b      (sum_b     ),
        .o_sums_valid (sums_valid)
    );

    wb_gain_calc u_gain_calc (
        .clk           (clk        ),
        .i_rst_n       (i_rst_n    ),
        .i_sum_r       (sum_r      ),
        .i_sum_g       (sum_g      ),
        .i_sum_b       (sum_b      ),
        .i_sums_valid  (sums_valid ),
        .o_gain_r      (gain_r     ),
        .o_gain_g      (gain_g     ),
        .o_gain_b      (gain_b     ),
        .o_gains_valid (gains_valid)
    );

    wb_pixel_fifo u_fifo (
        .clk     (clk       ),
        .i_rst_n (i_rst_n   ),
        .i_wr    (fifo_wr   ),
        .i_wdata (fifo_wdata),
        .i_rd    (fifo_rd   ),
        .o_rdata (fifo_rdata),
        .o_empty (fifo_empty),
        .o_full  (fifo_full )
    );

    wb_gain_apply u_apply (
        .clk           (clk        ),
        .i_rst_n       (i_rst_n    ),
        .i_wb_en       (i_wb_en    ),
        .i_gain_r      (gain_r     ),
        .i_gain_g      (gain_g     ),
        .i_gain_b      (gain_b     ),
        .i_gains_valid (gains_valid),
        .i_fifo_data   (fifo_rdata ),
        .i_fifo_empty  (fifo_empty ),
        .i_ready       (i_ready    ),
        .o_fifo_rd     (fifo_rd    ),
        .o_valid       (o_valid    ),
        .o_r           (o_r        ),
        .o_g           (o_g        ),
        .o_b           (o_b        ),
        .o_last        (o_last     )
    );

endmodule : wb_top

`default_nettype wire

// ==== testbench/tb_clkgen.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clkgen (
    output logic clk,
    output logic o_rst_n
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 ns period.
    end

    initial begin
        o_rst_n = 1'b0;
        repeat (2) @(posedge clk);
        o_rst_n <= 1'b1;
    end

endmodule : tb_clkgen

`default_nettype wire

// ==== testbench/tb_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_top;
    import wb_pkg::*;

    localparam int GAP        = 60;
    localparam int NUM_FRAMES = 7;
    localparam int TOTAL_PIX  = 6 * 16 + 32;
    localparam int WATCHDOG   = TOTAL_PIX * 8 + NUM_FRAMES * (GAP + 50);

    logic              clk;
    logic              rst_n;
    logic              i_wb_en;
    logic              i_valid;
    logic [PIX_W-1:0]  i_r;
    logic [PIX_W-1:0]  i_g;
    logic [PIX_W-1:0]  i_b;
    logic              i_last;
    logic              o_ready;
    logic              o_valid;
    logic [PIX_W-1:0]  o_r;
    logic [PIX_W-1:0]  o_g;
    logic [PIX_W-1:0]  o_b;
    logic              o_last;
    logic              i_ready;

    int                seed       = 19649;
    logic              rand_ready = 1'b0;
    logic              saw_full   = 1'b0;
    int                in_count   = 0;
    int                out_count  = 0;
    int                gain_r     = 256;  // model gains, unity after reset.
    int                gain_g     = 256;
    int                gain_b     = 256;
    longint            sum_r      = 0;
    longint            sum_g      = 0;
    longint            sum_b      = 0;
    logic [FIFO_W-1:0] exp_q[$];          // {last, r, g, b}.

    tb_clkgen u_clkgen (
        .clk     (clk  ),
        .o_rst_n (rst_n)
    );

    wb_top i_dut (
        .clk     (clk    ),
        .i_rst_n (rst_n  ),
        .i_wb_en (i_wb_en),
        .i_valid (i_valid),
        .i_r     (i_r    ),
        .i_g     (i_g    ),
        .i_b     (i_b    ),
        .i_last  (i_last ),
        .o_ready (o_ready),
        .o_valid (o_valid),
        .o_r     (o_r    ),
        .o_g     (o_g    ),
        .o_b     (o_b    ),
        .o_last  (o_last ),
        .i_ready (i_ready)
    );

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_pixel(input logic [PIX_W-1:0] r, input logic [PIX_W-1:0] g,
                               input logic [PIX_W-1:0] b, input logic last,
                               input logic [FIFO_W-1:0] want);
        if (r !== want[3*PIX_W-1 -: PIX_W]) begin
            fail_now($sformatf("mismatch o_r (pixel %0d): got %h expected %h",
                               out_count, r, want[3*PIX_W-1 -: PIX_W]));
        end
        if (g !== want[2*PIX_W-1 -: PIX_W]) begin
            fail_now($sformatf("mismatch o_g (pixel %0d): got %h expected %h",
                               out_count, g, want[2*PIX_W-1 -: PIX_W]));
        end
        if (b !== want[PIX_W-1:0]) begin
            fail_now($sformatf("mismatch o_b (pixel %0d): got %h expected %h",
                               out_count, b, want[PIX_W-1:0]));
        end
        if (last !== want[3*PIX_W]) begin
            fail_now($sformatf("mismatch o_last (pixel %0d): got %h expected %h",
                               out_count, last, want[3*PIX_W]));
        end
    endtask

    task automatic check_count(input string name, input int got, input int want);
        if (got != want) begin
            fail_now($sformatf("mismatch %s: got %h expected %h", name, got, want));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic want);
        if (got !== want) begin
            fail_now($sformatf("mismatch %s: got %h expected %h", name, got, want));
        end
    endtask

    // gray-world gain: mean of all sums over this channel's sum.
    function automatic int calc_gain(input longint sum, input longint total);
        longint q;
        if (sum == 0) begin
            return int'(GAIN_UNITY);
        end
        q = (total << GAIN_FRAC) / (3 * sum);
        return (q > 1023) ? 1023 : int'(q);
    endfunction

    function automatic logic [PIX_W-1:0] scale(input logic [PIX_W-1:0] pix, input int gain);
        int prod;
        prod = (int'(pix) * gain) >> GAIN_FRAC;
        return (prod > 255) ? 8'hFF : 8'(prod);
    endfunction

    function automatic logic [PIX_W-1:0] pixel_value(input int frame, input int idx,
                                                     input int ch);
        case (frame)
            0:       return 8'(40 + 40 * ch + idx);
            1:       return 8'(100 + 8 * idx - 30 * ch);   // red clips at 255.
            2:       return (ch == 2) ? 8'd0 : 8'(60 + 30 * ch + idx);
            3:       return (ch != 0) ? 8'd200 : ((idx == 0) ? 8'd1 : 8'd0);
            4:       return 8'(3 * idx + 50 * ch);
            default: return 8'($random(seed));
        endcase
    endfunction

    // called right after a rising edge, returns on the edge of the transfer.
    task automatic drive_pixel(input logic [PIX_W-1:0] r, input logic [PIX_W-1:0] g,
                               input logic [PIX_W-1:0] b, input logic last);
        logic taken;
        i_valid <= 1'b1;
        i_r     <= r;
        i_g     <= g;
        i_b     <= b;
        i_last  <= last;
        taken = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = o_ready;
            @(posedge clk);
        end
        in_count++;
    endtask

    task automatic send_frame(input int frame, input int n, input logic en);
        logic [PIX_W-1:0] r;
        logic [PIX_W-1:0] g;
        logic [PIX_W-1:0] b;
        logic             last;
        longint           total;
        for (int i = 0; i < n; i++) begin
            r    = pixel_value(frame, i, 0);
            g    = pixel_value(frame, i, 1);
            b    = pixel_value(frame, i, 2);
            last = (i == n - 1);
            if (en) begin
                exp_q.push_back({last, scale(r, gain_r), scale(g, gain_g), scale(b, gain_b)});
            end else begin
                exp_q.push_back({last, r, g, b});
            end
            sum_r += longint'(r);
            sum_g += longint'(g);
            sum_b += longint'(b);
            drive_pixel(r, g, b, last);
        end
        i_valid <= 1'b0;
        total  = sum_r + sum_g + sum_b;
        gain_r = calc_gain(sum_r, total);  // used from the next frame on.
        gain_g = calc_gain(sum_g, total);
        gain_b = calc_gain(sum_b, total);
        sum_r  = 0;
        sum_g  = 0;
        sum_b  = 0;
    endtask

    task automatic run_frame(input int frame, input int n, input logic en);
        int waited;
        send_frame(frame, n, en);
        waited = 0;
        while (exp_q.size() > 0 && waited < n * 8) begin
            @(posedge clk);
            waited++;
        end
        repeat (GAP) @(posedge clk);
        check_count("output pixel count", out_count, in_count);
    endtask

    task automatic test_passthrough();
        run_frame(0, 16, 1'b1);
    endtask

    task automatic test_scaled();
        run_frame(1, 16, 1'b1);
    endtask

    task automatic test_gain_limits();
        run_frame(2, 16, 1'b1);  // blue all zero.
        run_frame(3, 16, 1'b1);  // red tiny, so gain saturates next frame.
        run_frame(4, 16, 1'b1);
    endtask

    task automatic test_bypass();
        i_wb_en <= 1'b0;
        run_frame(5, 16, 1'b0);
        i_wb_en <= 1'b1;
    endtask

    task automatic test_backpressure();
        saw_full   = 1'b0;
        rand_ready = 1'b1;
        run_frame(6, 32, 1'b1);
        rand_ready = 1'b0;
        if (!saw_full) begin
            fail_now("o_ready never went low while the sink stalled the output");
        end
    endtask

    // sink, about one cycle in four ready under back-pressure.
    initial begin
        i_ready = 1'b1;
        forever begin
            @(posedge clk);
            i_ready <= rand_ready ? (($random(seed) & 3) == 0) : 1'b1;
        end
    end

    always @(negedge clk) begin : output_monitor
        logic [FIFO_W-1:0] want;
        if (!o_ready) begin
            saw_full = 1'b1;
        end
        if (o_valid && i_ready) begin
            if (exp_q.size() == 0) begin
                fail_now("output pixel seen while no pixel was expected");
            end else begin
                want = exp_q.pop_front();
                check_pixel(o_r, o_g, o_b, o_last, want);
                out_count++;
            end
        end
    end

    initial begin
        repeat (WATCHDOG) @(posedge clk);
        fail_now("timeout: the tests did not finish in time");
    end

    initial begin
        i_wb_en = 1'b1;
        i_valid = 1'b0;
        i_r     = '0;
        i_g     = '0;
        i_b     = '0;
        i_last  = 1'b0;
        wait (rst_n === 1'b1);
        @(negedge clk);
        check_flag("o_valid", o_valid, 1'b0);
        check_flag("o_ready", o_ready, 1'b1);
        @(posedge clk);
        test_passthrough();
        test_scaled();
        test_gain_limits();
        test_bypass();
        test_backpressure();
        $display("TEST OK");
        $finish;
    end

endmodule : tb_top

`default_nettype wire

// ==== tb.f ====
hdl/wb_pkg.sv
hdl/wb_frame_stats.sv
hdl/wb_gain_calc.sv
hdl/wb_pixel_fifo.sv
hdl/wb_gain_apply.sv
hdl/wb_top.sv
testbench/tb_clkgen.sv
testbench/tb_top.sv

// ==== run.sh ====
#!/bin/sh
# build and run the white balance testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_top -f tb.f -o tb_sim

out=$(./obj_dir/tb_sim) || true
echo "$out"

if echo "$out" | grep -qx "TEST OK"; then
    exit 0
else
    exit 1
fi
